//--- hw/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic                   clk,
    input  logic                   rst,
    line_wr_if.buffer              lwr,
    input  logic [7:0]             rd_addr,
    output tilemap_pkg::tile_pix_t rd_pix
);

    // bank written by the renderer, the other one is on display
    tilemap_pkg::tile_pix_t bank0 [0:tilemap_pkg::LINE_PIXELS - 1];
    tilemap_pkg::tile_pix_t bank1 [0:tilemap_pkg::LINE_PIXELS - 1];

    logic                   wr_ok;
    tilemap_pkg::tile_pix_t rd_word;

    assign wr_ok = lwr.we && !lwr.addr[8];  // off-line pixels dropped

    always_ff @(posedge clk) begin
        if (wr_ok && !lwr.wr_bank) begin
            bank0[lwr.addr[7:0]] <= lwr.din;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && lwr.wr_bank) begin
            bank1[lwr.addr[7:0]] <= lwr.din;
        end
    end

    // display side reads the finished bank
    assign rd_word = lwr.wr_bank ? bank0[rd_addr] : bank1[rd_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pix <= '0;
        end else begin
            rd_pix <= rd_word;  // one cycle after rd_addr
        end
    end

endmodule

//--- hw/tile_decode.sv
`timescale 1ns/1ps

module tile_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           map_we,
    input  logic [tilemap_pkg::MAP_AW-1:0] map_addr,
    input  logic [15:0]                    map_data,
    input  logic                           pal_msb,
    input  logic                           extra_en,
    input  logic [2:0]                     extra_mask,
    input  logic [2:0]                     extra_bits,
    tile_info_if.decode                    dec
);

    // entry layout: attribute in the high byte, code in the low byte
    logic [15:0] map_ram [0:(1 << tilemap_pkg::MAP_AW) - 1];

    logic [15:0]             rd_word;
    logic [7:0]              attr;
    logic [2:0]              ext_sel;
    logic [2:0]              bank_hi;
    tilemap_pkg::tile_info_t info_q;
    logic                    info_valid_q;

    always_ff @(posedge clk) begin
        if (map_we) begin
            map_ram[map_addr] <= map_data;
        end
    end

    // a read hitting the entry being written returns the CPU data
    assign rd_word = (map_we && map_addr == dec.map_rd_addr) ? map_data
                                                             : map_ram[dec.map_rd_addr];
    assign attr    = rd_word[15:8];

    // register bank bits override the attribute where enabled
    assign ext_sel = {3{extra_en}} & extra_mask;
    assign bank_hi = (extra_bits & ext_sel)
                   | (attr[tilemap_pkg::ATTR_BANK_HI_MSB:tilemap_pkg::ATTR_BANK_HI_LSB]
                      & ~ext_sel);

    always_ff @(posedge clk) begin
        if (dec.map_rd) begin
            info_q.code <= {bank_hi, attr[tilemap_pkg::ATTR_BANK0], rd_word[7:0]};
            info_q.pal  <= {pal_msb & attr[tilemap_pkg::ATTR_BANK_HI_LSB],
                            attr[tilemap_pkg::ATTR_PAL_MSB:tilemap_pkg::ATTR_PAL_LSB]};
            info_q.prio <= attr[tilemap_pkg::ATTR_PRIO];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            info_valid_q <= 1'b0;
        end else begin
            info_valid_q <= dec.map_rd;  // single pulse per read
        end
    end

    assign dec.info       = info_q;
    assign dec.info_valid = info_valid_q;

endmodule

//--- hw/tile_fetch.sv
`timescale 1ns/1ps

module tile_fetch (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           line_start,
    input  logic [7:0]                     hscroll,
    input  logic [7:0]                     vscroll,
    input  logic [7:0]                     vline,
    input  logic                           flip,
    output logic                           rom_cs,
    output logic [tilemap_pkg::ROM_AW-1:0] rom_addr,
    input  logic                           rom_ok,
    input  logic [15:0]                    rom_data,
    output logic                           done,
    tile_info_if.fetch                     tinfo,
    line_wr_if.fetch                       lwr
);

    localparam logic [6:0] LAST_WORD = 7'(tilemap_pkg::FETCH_WORDS - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MAP,
        ST_INFO,
        ST_ROM,
        ST_DUMP,
        ST_NEXT
    } state_t;

    state_t                  st;
    logic [7:0]              hn;        // source column of current word
    logic [7:0]              vn;        // source row
    logic [8:0]              waddr;     // unflipped line position
    logic [6:0]              word_cnt;
    logic [1:0]              pix_cnt;
    logic [15:0]             pix_data;
    tilemap_pkg::tile_info_t tile;
    logic                    need_tile;
    logic                    map_rd;
    logic                    we;
    logic [8:0]              wr_addr;
    tilemap_pkg::tile_pix_t  din;
    logic                    wr_bank;

    // first word may be the right half of a tile
    assign need_tile = (word_cnt == 7'd0) || !hn[2];

    assign tinfo.map_rd_addr = {vn[7:3], hn[7:3]};
    assign tinfo.map_rd      = map_rd;
    assign rom_addr          = {tile.code, vn[2:0], hn[2]};

    assign lwr.we      = we;
    assign lwr.addr    = wr_addr;
    assign lwr.din     = din;
    assign lwr.wr_bank = wr_bank;

    always_ff @(posedge clk) begin
        if (rst) begin
            st      <= ST_IDLE;
            done    <= 1'b1;
            rom_cs  <= 1'b0;
            map_rd  <= 1'b0;
            we      <= 1'b0;
            wr_bank <= 1'b0;
        end else begin
            map_rd <= 1'b0;
            we     <= 1'b0;
            if (line_start) begin
                // a new line aborts whatever was in progress
                wr_bank  <= ~wr_bank;
                done     <= 1'b0;
                rom_cs   <= 1'b0;
                hn       <= {hscroll[7:2], 2'b00};
                vn       <= (vline ^ {8{flip}}) + vscroll;
                waddr    <= 9'd0 - {7'd0, hscroll[1:0]};
                word_cnt <= 7'd0;
                st       <= ST_MAP;
            end else begin
                case (st)
                    ST_MAP: begin
                        if (need_tile) begin
                            map_rd <= 1'b1;
                            st     <= ST_INFO;
                        end else begin
                            rom_cs <= 1'b1;  // same tile, next half
                            st     <= ST_ROM;
                        end
                    end
                    ST_INFO: begin
                        if (tinfo.info_valid) begin
                            tile   <= tinfo.info;
                            rom_cs <= 1'b1;
                            st     <= ST_ROM;
                        end
                    end
                    ST_ROM: begin
                        if (rom_ok) begin
                            pix_data <= rom_data;
                            rom_cs   <= 1'b0;
                            pix_cnt  <= 2'd0;
                            st       <= ST_DUMP;
                        end
                    end
                    ST_DUMP: begin
                        // leftmost pixel sits in the top nibble
                        we        <= 1'b1;
                        wr_addr   <= flip ? {waddr[8], 8'd255 - waddr[7:0]} : waddr;
                        din.prio  <= tile.prio;
                        din.pal   <= tile.pal;
                        din.color <= pix_data[15:12];
                        pix_data  <= {pix_data[11:0], 4'd0};
                        waddr     <= waddr + 9'd1;
                        pix_cnt   <= pix_cnt + 2'd1;
                        if (pix_cnt == 2'd3) begin
                            st <= ST_NEXT;
                        end
                    end
                    ST_NEXT: begin
                        hn       <= hn + 8'd4;  // wraps column 31 to 0
                        word_cnt <= word_cnt + 7'd1;
                        if (word_cnt == LAST_WORD) begin
                            done <= 1'b1;
                            st   <= ST_IDLE;
                        end else begin
                            st <= ST_MAP;
                        end
                    end
                    default: st <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

//--- hw/tilemap_if.sv
`timescale 1ns/1ps

// map read request and decoded tile answer
interface tile_info_if;
    logic [tilemap_pkg::MAP_AW-1:0] map_rd_addr;
    logic                           map_rd;
    tilemap_pkg::tile_info_t        info;        // held until next read
    logic                           info_valid;  // one cycle after map_rd

    modport fetch (
        output map_rd_addr,
        output map_rd,
        input  info,
        input  info_valid
    );

    modport decode (
        input  map_rd_addr,
        input  map_rd,
        output info,
        output info_valid
    );
endinterface

// pixel writes into the line memory
interface line_wr_if;
    logic                    we;
    logic [8:0]              addr;     // bit 8 set means off the line
    tilemap_pkg::tile_pix_t  din;
    logic                    wr_bank;

    modport fetch (output we, output addr, output din, output wr_bank);

    modport buffer (input we, input addr, input din, input wr_bank);
endinterface

//--- hw/tilemap_pkg.sv
package tilemap_pkg;

    // one line buffer entry
    typedef struct packed {
        logic       prio;
        logic [3:0] pal;
        logic [3:0] color;
    } tile_pix_t;

    // tile description after attribute decode
    typedef struct packed {
        logic [11:0] code;  // bank (4) and map code (8)
        logic [3:0]  pal;
        logic        prio;
    } tile_info_t;

    // attribute byte layout
    localparam int ATTR_BANK0       = 7;
    localparam int ATTR_PRIO        = 6;
    localparam int ATTR_BANK_HI_MSB = 5;
    localparam int ATTR_BANK_HI_LSB = 3;
    localparam int ATTR_PAL_MSB     = 2;
    localparam int ATTR_PAL_LSB     = 0;

    // geometry
    localparam int LINE_PIXELS = 256;
    localparam int FETCH_WORDS = 65;   // 260 pixels, covers the fine scroll offset
    localparam int MAP_AW      = 10;   // 32x32 map
    localparam int ROM_AW      = 16;   // code, row, half tile

endpackage

//--- hw/tilemap_top.sv
`timescale 1ns/1ps

module tilemap_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           hs,
    input  logic                           vblank_n,
    input  logic                           map_we,
    input  logic [tilemap_pkg::MAP_AW-1:0] map_addr,
    input  logic [15:0]                    map_data,
    input  logic [7:0]                     hscroll,
    input  logic [7:0]                     vscroll,
    input  logic [7:0]                     vline,
    input  logic                           flip,
    input  logic                           pal_msb,
    input  logic                           extra_en,
    input  logic [2:0]                     extra_mask,
    input  logic [2:0]                     extra_bits,
    output logic                           rom_cs,
    output logic [tilemap_pkg::ROM_AW-1:0] rom_addr,
    input  logic                           rom_ok,
    input  logic [15:0]                    rom_data,
    input  logic [7:0]                     rd_addr,
    output tilemap_pkg::tile_pix_t         rd_pix,
    output logic                           done
);

    logic [1:0] hs_d;        // sampled sync history
    logic       line_start;

    tile_info_if tinfo ();
    line_wr_if   lwr ();

    // rising hs outside vertical blank, two cycles after the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            hs_d       <= 2'b00;
            line_start <= 1'b0;
        end else begin
            hs_d       <= {hs_d[0], hs};
            line_start <= hs_d[0] && !hs_d[1] && vblank_n;
        end
    end

    tile_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .map_we     (map_we),
        .map_addr   (map_addr),
        .map_data   (map_data),
        .pal_msb    (pal_msb),
        .extra_en   (extra_en),
        .extra_mask (extra_mask),
        .extra_bits (extra_bits),
        .dec        (tinfo.decode)
    );

    tile_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .hscroll    (hscroll),
        .vscroll    (vscroll),
        .vline      (vline),
        .flip       (flip),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .done       (done),
        .tinfo      (tinfo.fetch),
        .lwr        (lwr.fetch)
    );

    line_buffer u_line (
        .clk     (clk),
        .rst     (rst),
        .lwr     (lwr.buffer),
        .rd_addr (rd_addr),
        .rd_pix  (rd_pix)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the tilemap testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tilemap_tb -f vlog.f -o tilemap_sim \
    > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tilemap_sim > sim.log 2>&1 || echo "simulator exited with an error"
grep -qx "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

//--- tb/tilemap_patterns.txt
# command and arguments per line, numbers in hex
#   fill salt          every map entry = (addr * 3b1d) ^ salt
#   wr   addr data     one map entry, attribute in the high byte
#   cfg  name value    hscroll vscroll flip pal_msb extra_en extra_mask extra_bits
#   line vline name    render one line and compare all 256 pixels
fill 0000
line 00 plain_top
line 2d plain_mid
cfg hscroll 01
line 10 hscroll_1
cfg hscroll 03
line 77 hscroll_3
cfg hscroll fd
line 08 hscroll_wrap
# row 4 columns 31 and 0 marked around the wrap seam
wr 009f c3a5
wr 0080 4a11
line 22 seam_row4
cfg vscroll 13
cfg flip 01
line 05 vscroll_flip
cfg hscroll 00
line c8 flip_only
fill 5a3c
cfg pal_msb 01
cfg extra_en 01
cfg extra_mask 05
cfg extra_bits 06
line 31 extra_bank
cfg extra_mask 02
line 31 extra_mask2
cfg extra_en 00
line 31 extra_off
cfg flip 00
cfg vscroll 00
cfg pal_msb 00
line 00 latency_repeat

//--- tb/tilemap_properties.sv
`timescale 1ns/1ps

module tilemap_properties (
    input logic                           clk,
    input logic                           rst,
    input logic                           line_start,
    input logic                           rom_cs,
    input logic [tilemap_pkg::ROM_AW-1:0] rom_addr,
    input logic                           rom_ok,
    input logic                           done,
    input logic                           we
);

    // request and address hold until rom_ok unless a new line starts
    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok && !line_start |=> rom_cs && $stable(rom_addr))
        else $error("rom_cs dropped or rom_addr moved before rom_ok");

    reset_done: assert property (@(posedge clk) $fell(rst) |-> done)
        else $error("done low in the first cycle after reset");

    idle_no_write: assert property (@(posedge clk) disable iff (rst) done |-> !we)
        else $error("line buffer write while done is high");

endmodule

bind tile_fetch tilemap_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .line_start (line_start),
    .rom_cs     (rom_cs),
    .rom_addr   (rom_addr),
    .rom_ok     (rom_ok),
    .done       (done),
    .we         (we)
);

//--- tb/tilemap_tb.sv
`timescale 1ns/1ps

module tilemap_tb;

    localparam logic [15:0] ROM_KEY   = 16'ha5c3;
    localparam int          LINE_WAIT = 4000;  // cycles, one line with the slowest ROM

    logic                   clk;
    logic                   rst;
    logic                   hs;
    logic                   vblank_n;
    logic                   map_we;
    logic [9:0]             map_addr;
    logic [15:0]            map_data;
    logic [7:0]             hscroll;
    logic [7:0]             vscroll;
    logic [7:0]             vline;
    logic                   flip;
    logic                   pal_msb;
    logic                   extra_en;
    logic [2:0]             extra_mask;
    logic [2:0]             extra_bits;
    logic                   rom_cs;
    logic [15:0]            rom_addr;
    logic                   rom_ok;
    logic [15:0]            rom_data;
    logic [7:0]             rd_addr;
    tilemap_pkg::tile_pix_t rd_pix;
    logic                   done;

    logic [15:0] map_model [0:1023];  // shadow of every CPU map write
    integer      seed;
    logic [31:0] rnd;
    int          rom_cnt;
    logic        rom_busy;
    int          n_tests;
    int          n_checks;
    int          n_errors;
    int          test_errors;
    logic        timed_out;

    tilemap_top dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // tile ROM, answers 0 to 4 cycles after rom_cs
    always @(posedge clk) begin
        #1;
        if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_busy = 1'b0;
        end else if (!rom_ok) begin
            if (!rom_busy) begin
                rnd      = $random(seed);
                rom_cnt  = int'(rnd % 32'd5);
                rom_busy = 1'b1;
            end
            if (rom_cnt == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_addr ^ ROM_KEY;
            end else begin
                rom_cnt--;
            end
        end
    end

    // expected display pixel x from the map shadow and the current settings
    function automatic tilemap_pkg::tile_pix_t model_pix(input logic [7:0] x);
        logic [7:0]             scr;
        logic [7:0]             col;
        logic [7:0]             row;
        logic [15:0]            ent;
        logic [2:0]             sel;
        logic [2:0]             bank;
        logic [15:0]            word;
        tilemap_pkg::tile_pix_t pix;
        scr  = flip ? 8'd255 - x : x;
        col  = scr + hscroll;  // wraps column 31 to 0
        row  = (flip ? ~vline : vline) + vscroll;
        ent  = map_model[{row[7:3], col[7:3]}];
        sel  = extra_en ? extra_mask : 3'b000;
        bank = (extra_bits & sel) | (ent[13:11] & ~sel);
        word = {bank, ent[15], ent[7:0], row[2:0], col[2]} ^ ROM_KEY;
        pix.prio = ent[14];
        pix.pal  = {pal_msb & ent[11], ent[10:8]};
        case (col[1:0])  // leftmost pixel in the top nibble
            2'd0:    pix.color = word[15:12];
            2'd1:    pix.color = word[11:8];
            2'd2:    pix.color = word[7:4];
            default: pix.color = word[3:0];
        endcase
        return pix;
    endfunction

    task automatic check_pix(input logic [7:0] x, input tilemap_pkg::tile_pix_t got,
                             input tilemap_pkg::tile_pix_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            test_errors++;
            $display("FAIL rd_pix x=%0d got %h expected %h", x, got, exp);
        end
    endtask

    task automatic check_done(input logic exp);
        n_checks++;
        if (done !== exp) begin
            n_errors++;
            test_errors++;
            $display("FAIL done got %h expected %h", done, exp);
        end
    endtask

    task automatic wait_done(input logic level, input string what);
        int n;
        if (timed_out) return;
        n = 0;
        while (done !== level && n < LINE_WAIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (done !== level) begin
            timed_out = 1'b1;
            n_errors++;
            $display("timeout after %0d cycles waiting for %0s", n, what);
        end
    endtask

    task automatic pulse_hs();
        @(posedge clk);
        #1;
        hs = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        hs = 1'b0;
    endtask

    task automatic write_map(input logic [9:0] addr, input logic [15:0] data);
        @(posedge clk);
        #1;
        map_we          = 1'b1;
        map_addr        = addr;
        map_data        = data;
        map_model[addr] = data;
        @(posedge clk);
        #1;
        map_we = 1'b0;
    endtask

    task automatic set_config(input logic [8*12-1:0] key, input logic [7:0] val);
        @(posedge clk);
        #1;
        case (key)
            96'("hscroll"):    hscroll    = val;
            96'("vscroll"):    vscroll    = val;
            96'("flip"):       flip       = val[0];
            96'("pal_msb"):    pal_msb    = val[0];
            96'("extra_en"):   extra_en   = val[0];
            96'("extra_mask"): extra_mask = val[2:0];
            96'("extra_bits"): extra_bits = val[2:0];
            default: begin
                n_errors++;
                $display("unknown setting %0s in the pattern file", key);
            end
        endcase
    endtask

    task automatic render_line(input logic [7:0] line_no, input logic [8*24-1:0] name);
        int x;
        n_tests++;
        test_errors = 0;
        wait_done(1'b1, "the previous line to finish");
        vline = line_no;
        pulse_hs();
        wait_done(1'b0, "the line to start");
        repeat (8) @(posedge clk);
        #1;
        if (!timed_out) check_done(1'b0);  // still rendering
        wait_done(1'b1, "the line to finish");
        pulse_hs();  // swap, rendered bank goes on display
        wait_done(1'b0, "the bank swap");
        if (timed_out) return;
        @(posedge clk);
        #1;
        rd_addr = 8'd0;
        for (x = 0; x < 256; x++) begin
            @(posedge clk);
            #1;
            check_pix(8'(x), rd_pix, model_pix(8'(x)));
            rd_addr = 8'(x + 1);
        end
        $display("test %0s: %0d mismatches over the line", name, test_errors);
    endtask

    task automatic run_patterns();
        integer          fd;
        integer          n;
        int              i;
        logic [31:0]     cmd;
        logic [8*12-1:0] key;
        logic [8*24-1:0] name;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [8*96-1:0] rest;
        fd = $fopen("tb/tilemap_patterns.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("cannot open tb/tilemap_patterns.txt");
            return;
        end
        n = $fscanf(fd, "%s", cmd);
        while (n == 1 && !timed_out) begin
            case (cmd)
                32'("#"): n = $fgets(rest, fd);
                32'("fill"): begin
                    n = $fscanf(fd, "%h", a);
                    for (i = 0; i < 1024; i++) begin
                        write_map(10'(i), 16'(i * 32'h3b1d) ^ a[15:0]);
                    end
                end
                32'("wr"): begin
                    n = $fscanf(fd, "%h %h", a, b);
                    write_map(a[9:0], b[15:0]);
                end
                32'("cfg"): begin
                    n = $fscanf(fd, "%s %h", key, a);
                    set_config(key, a[7:0]);
                end
                32'("line"): begin
                    n = $fscanf(fd, "%h %s", a, name);
                    render_line(a[7:0], name);
                end
                default: begin
                    n_errors++;
                    $display("unknown command %0s in the pattern file", cmd);
                end
            endcase
            n = $fscanf(fd, "%s", cmd);
        end
        $fclose(fd);
    endtask

    initial begin
        seed        = 32'hdfa1_75fe;
        rst         = 1'b1;
        hs          = 1'b0;
        vblank_n    = 1'b1;
        map_we      = 1'b0;
        map_addr    = '0;
        map_data    = '0;
        hscroll     = '0;
        vscroll     = '0;
        vline       = '0;
        flip        = 1'b0;
        pal_msb     = 1'b0;
        extra_en    = 1'b0;
        extra_mask  = '0;
        extra_bits  = '0;
        rom_ok      = 1'b0;
        rom_data    = '0;
        rd_addr     = '0;
        rom_busy    = 1'b0;
        rom_cnt     = 0;
        n_tests     = 1;
        n_checks    = 0;
        n_errors    = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_done(1'b1);  // idle right after reset
        $display("test reset: %0d mismatches on done", test_errors);
        run_patterns();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/tilemap_pkg.sv
hw/tilemap_if.sv
hw/tile_decode.sv
hw/tile_fetch.sv
hw/line_buffer.sv
hw/tilemap_top.sv
tb/tilemap_properties.sv
tb/tilemap_tb.sv
